// ==== bench/tb_trap_unit.sv ====
module tb_trap_unit;

	import trap_pkg::*;

	localparam int NUM_TESTS    = 6;
	localparam int CLOCK_PERIOD = 20;

	logic     clock;
	logic     reset;
	csr_req_t csr_req;
	xlen_t    csr_rdata;
	logic     external_interrupt;
	logic     ecall;
	logic     irq_pending;
	xlen_t    irq_pc;
	logic     irq_dispatched;
	xlen_t    irq_epc;
	xlen_t    epc;
	wb_req_t  wb;
	xlen_t    wb_dat;
	logic     wb_ack;
	int       errors;
	xlen_t    mtvec_val;

	trap_unit_top u_dut (
		.i_clock              (clock),
		.i_reset              (reset),
		.i_csr_req            (csr_req),
		.o_csr_rdata          (csr_rdata),
		.i_external_interrupt (external_interrupt),
		.i_ecall              (ecall),
		.o_irq_pending        (irq_pending),
		.o_irq_pc             (irq_pc),
		.i_irq_dispatched     (irq_dispatched),
		.i_irq_epc            (irq_epc),
		.o_epc                (epc),
		.i_wb                 (wb),
		.o_wb_dat             (wb_dat),
		.o_wb_ack             (wb_ack)
	);

	initial begin
		clock = 1'b0;
		forever #(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// ==================================================
	// compare and driver tasks
	// ==================================================
	task automatic check_word(input string what, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			$display("error at time %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error at time %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic csr_write(input csr_addr_t index, input xlen_t data);
		@(posedge clock);
		csr_req <= {index, 1'b1, data};
		@(posedge clock);
		csr_req <= '0;
	endtask

	// the read mux is combinational, so the value is taken half a cycle later
	task automatic csr_read(input csr_addr_t index, output xlen_t data);
		@(posedge clock);
		csr_req <= {index, 1'b0, 32'h0};
		@(negedge clock);
		data = csr_rdata;
	endtask

	task automatic expect_csr(input string what, input csr_addr_t index, input xlen_t exp);
		xlen_t value;
		csr_read(index, value);
		check_word(what, value, exp);
	endtask

	task automatic wait_ack(input wb_addr_t adr);
		int n;
		n = 0;
		@(negedge clock);
		while (!wb_ack && n < 8) begin
			@(negedge clock);
			n++;
		end
		if (!wb_ack) begin
			$display("no Wishbone ack came back for address %h", adr);
			errors++;
		end
	endtask

	task automatic wb_write(input wb_addr_t adr, input xlen_t data);
		@(posedge clock);
		wb <= {3'b111, adr, data};
		wait_ack(adr);
		@(posedge clock);
		wb <= '0;
	endtask

	task automatic wb_read(input wb_addr_t adr, output xlen_t data);
		@(posedge clock);
		wb <= {3'b110, adr, 32'h0};
		wait_ack(adr);
		data = wb_dat;
		@(posedge clock);
		wb <= '0;
	endtask

	task automatic pulse_ecall();
		@(posedge clock);
		ecall <= 1'b1;
		@(posedge clock);
		ecall <= 1'b0;
	endtask

	task automatic dispatch(input xlen_t return_pc);
		@(posedge clock);
		irq_dispatched <= 1'b1;
		irq_epc        <= return_pc;
		@(posedge clock);
		irq_dispatched <= 1'b0;
	endtask

	task automatic wait_pending(input int max_cycles, output logic seen);
		int n;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < max_cycles) begin
			@(negedge clock);
			seen = irq_pending;
			n++;
		end
	endtask

	// ==================================================
	// directed tests
	// ==================================================
	task automatic test_reset_values();
		expect_csr("mie", CSR_MIE, '0);
		expect_csr("mtvec", CSR_MTVEC, '0);
		expect_csr("mepc", CSR_MEPC, '0);
		expect_csr("mcause", CSR_MCAUSE, '0);
		expect_csr("mip", CSR_MIP, '0);
		expect_csr("mvendorid", CSR_MVENDORID, MVENDORID);
		expect_csr("marchid", CSR_MARCHID, MARCHID);
		expect_csr("mimpid", CSR_MIMPID, MIMPID);
		expect_csr("mhartid", CSR_MHARTID, MHARTID);
		expect_csr("unlisted csr", 12'h300, '0);
		check_bit("pending after reset", irq_pending, 1'b0);
	endtask

	task automatic test_csr_access();
		csr_write(CSR_MIE, '1);
		expect_csr("mie mask", CSR_MIE, 32'h0000_0888);
		mtvec_val = $urandom();
		csr_write(CSR_MTVEC, mtvec_val);
		expect_csr("mtvec", CSR_MTVEC, mtvec_val);
		csr_write(CSR_MEPC, $urandom());
		expect_csr("mepc after write", CSR_MEPC, '0);
		csr_write(CSR_MVENDORID, $urandom());
		expect_csr("mvendorid after write", CSR_MVENDORID, MVENDORID);
		csr_write(CSR_MIE, '0);
	endtask

	task automatic test_timer_regs();
		xlen_t cmp;
		xlen_t t0;
		xlen_t t1;
		xlen_t t2;
		cmp = $urandom();
		wb_write(TMR_CMP, cmp);
		wb_read(TMR_CMP, t0);
		check_word("timer compare", t0, cmp);
		wb_write(TMR_CTRL, 32'h1);
		wb_read(TMR_TIME, t0);
		wb_read(TMR_TIME, t1);
		check_bit("mtime counting up", t1 > t0, 1'b1);
		wb_write(TMR_CTRL, 32'h3);
		wb_read(TMR_TIME, t2);
		check_bit("mtime after clear", t2 < t1, 1'b1);
		wb_write(TMR_CTRL, 32'h0);
		wb_read(TMR_TIME, t0);
		wb_read(TMR_TIME, t1);
		check_word("stopped mtime", t1, t0);
	endtask

	task automatic test_timer_irq();
		xlen_t t;
		logic  seen;
		wb_write(TMR_CTRL, 32'h1);
		wb_read(TMR_TIME, t);
		wb_write(TMR_CMP, t - 32'd1);
		repeat (2) @(posedge clock);
		csr_read(CSR_MIP, t);
		check_bit("mip.mtip", t[MIP_MTIP_BIT], 1'b1);
		wait_pending(10, seen);
		check_bit("pending with mtie clear", seen, 1'b0);
		csr_write(CSR_MIE, 32'h1 << MIP_MTIP_BIT);
		wait_pending(10, seen);
		check_bit("pending from timer", seen, 1'b1);
		check_word("handler address", irq_pc, mtvec_val);
		expect_csr("timer cause", CSR_MCAUSE, CAUSE_M_TIMER);
		// drop the source before dispatch so the timer is not taken again
		csr_write(CSR_MIE, '0);
		wb_write(TMR_CTRL, 32'h0);
		dispatch(32'h0);
	endtask

	task automatic test_external_and_ecall();
		logic seen;
		csr_write(CSR_MIE, 32'h1 << MIP_MEIP_BIT);
		@(posedge clock);
		external_interrupt <= 1'b1;
		wait_pending(10, seen);
		check_bit("pending from external", seen, 1'b1);
		expect_csr("external cause", CSR_MCAUSE, CAUSE_M_EXTERNAL);
		@(posedge clock);
		external_interrupt <= 1'b0;
		dispatch(32'h0);
		csr_write(CSR_MIE, '0);
		pulse_ecall();
		wait_pending(10, seen);
		check_bit("pending from ecall", seen, 1'b1);
		expect_csr("ecall cause", CSR_MCAUSE, CAUSE_ECALL_M);
		dispatch(32'h0);
		csr_write(CSR_MIE, 32'h1 << MIP_MEIP_BIT);
		@(posedge clock);
		ecall              <= 1'b1;
		external_interrupt <= 1'b1;
		@(posedge clock);
		ecall <= 1'b0;
		wait_pending(10, seen);
		check_bit("pending from ecall and external", seen, 1'b1);
		expect_csr("cause with both sources", CSR_MCAUSE, CAUSE_ECALL_M);
		repeat (3) @(posedge clock);
		expect_csr("cause held while pending", CSR_MCAUSE, CAUSE_ECALL_M);
	endtask

	// the external level from the previous test is still high here
	task automatic test_dispatch();
		xlen_t return_pc;
		logic  seen;
		return_pc = $urandom();
		dispatch(return_pc);
		@(negedge clock);
		check_bit("pending after dispatch", irq_pending, 1'b0);
		check_word("o_epc", epc, return_pc);
		expect_csr("mepc", CSR_MEPC, return_pc);
		wait_pending(10, seen);
		check_bit("external taken again", seen, 1'b1);
		expect_csr("second external cause", CSR_MCAUSE, CAUSE_M_EXTERNAL);
		@(posedge clock);
		external_interrupt <= 1'b0;
		dispatch(32'h0);
	endtask

	initial begin
		#(NUM_TESTS * 200 * CLOCK_PERIOD);
		$display("timeout, the tests did not finish in time");
		$display("Test failed");
		$finish;
	end

	initial begin
		void'($urandom(32'ha5f9_876d));
		errors = 0;
		reset              <= 1'b1;
		csr_req            <= '0;
		external_interrupt <= 1'b0;
		ecall              <= 1'b0;
		irq_dispatched     <= 1'b0;
		irq_epc            <= '0;
		wb                 <= '0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		test_reset_values();
		test_csr_access();
		test_timer_regs();
		test_timer_irq();
		test_external_and_ecall();
		test_dispatch();
		$display("checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
hw/trap_pkg.sv
hw/machine_csr.sv
hw/timer_regs.sv
hw/machine_timer.sv
hw/trap_unit_top.sv
bench/tb_trap_unit.sv

// ==== hw/machine_csr.sv ====
module machine_csr (
	input  logic               i_clock,
	input  logic               i_reset,

	input  trap_pkg::csr_req_t i_csr_req,
	output trap_pkg::xlen_t    o_csr_rdata,

	input  logic               i_timer_irq,
	input  logic               i_external_interrupt,
	input  logic               i_ecall,

	output logic               o_irq_pending,
	output trap_pkg::xlen_t    o_irq_pc,
	input  logic               i_irq_dispatched,
	input  trap_pkg::xlen_t    i_irq_epc,
	output trap_pkg::xlen_t    o_epc
);

	import trap_pkg::*;

	logic  mie_msie;
	logic  mie_mtie;
	logic  mie_meie;
	xlen_t mtvec;
	xlen_t mepc;
	xlen_t mcause;

	xlen_t mie;
	xlen_t mip;

	logic  take_trap;
	xlen_t trap_cause;

	always_comb begin
		mie = '0;
		mie[MIP_MSIP_BIT] = mie_msie;
		mie[MIP_MTIP_BIT] = mie_mtie;
		mie[MIP_MEIP_BIT] = mie_meie;
	end

	// mip is not stored, it follows the source levels directly
	always_comb begin
		mip = '0;
		mip[MIP_MTIP_BIT] = i_timer_irq;
		mip[MIP_MEIP_BIT] = i_external_interrupt;
	end

	assign o_epc = mepc;

	// ==================================================
	// CSR access
	// ==================================================
	always_comb begin
		case (i_csr_req.index)
			CSR_MIE:       o_csr_rdata = mie;
			CSR_MTVEC:     o_csr_rdata = mtvec;
			CSR_MEPC:      o_csr_rdata = mepc;
			CSR_MCAUSE:    o_csr_rdata = mcause;
			CSR_MIP:       o_csr_rdata = mip;
			CSR_MVENDORID: o_csr_rdata = MVENDORID;
			CSR_MARCHID:   o_csr_rdata = MARCHID;
			CSR_MIMPID:    o_csr_rdata = MIMPID;
			CSR_MHARTID:   o_csr_rdata = MHARTID;
			default:       o_csr_rdata = '0;
		endcase
	end

	// only mie and mtvec are writable from the core
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mie_msie <= 1'b0;
			mie_mtie <= 1'b0;
			mie_meie <= 1'b0;
			mtvec    <= '0;
		end else if (i_csr_req.write) begin
			case (i_csr_req.index)
				CSR_MIE: begin
					mie_msie <= i_csr_req.wdata[MIP_MSIP_BIT];
					mie_mtie <= i_csr_req.wdata[MIP_MTIP_BIT];
					mie_meie <= i_csr_req.wdata[MIP_MEIP_BIT];
				end
				CSR_MTVEC: mtvec <= i_csr_req.wdata;
				default: ;
			endcase
		end
	end

	// ==================================================
	// trap acceptance and dispatch
	// ==================================================

	// ecall wins over external, external over timer
	always_comb begin
		take_trap  = 1'b0;
		trap_cause = '0;
		if (!o_irq_pending) begin
			if (i_ecall) begin
				take_trap  = 1'b1;
				trap_cause = CAUSE_ECALL_M;
			end else if (i_external_interrupt && mie_meie) begin
				take_trap  = 1'b1;
				trap_cause = CAUSE_M_EXTERNAL;
			end else if (i_timer_irq && mie_mtie) begin
				take_trap  = 1'b1;
				trap_cause = CAUSE_M_TIMER;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_irq_pending <= 1'b0;
			mcause        <= '0;
			mepc          <= '0;
		end else if (take_trap) begin
			o_irq_pending <= 1'b1;
			mcause        <= trap_cause;
		end else if (i_irq_dispatched) begin
			o_irq_pending <= 1'b0;
			mepc          <= i_irq_epc;
		end
	end

	// handler address is captured once per accepted trap
	always_ff @(posedge i_clock) begin
		if (take_trap) begin
			o_irq_pc <= mtvec;
		end
	end

	// the core may only report a dispatch for a trap it was shown
	a_dispatch_while_pending: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_irq_dispatched |-> o_irq_pending
	);

endmodule

// ==== hw/machine_timer.sv ====
module machine_timer (
	input  logic                 i_clock,
	input  logic                 i_reset,

	input  trap_pkg::timer_cfg_t i_cfg,

	output trap_pkg::xlen_t      o_mtime,
	output logic                 o_timer_irq
);

	import trap_pkg::*;

	xlen_t mtime;

	assign o_mtime = mtime;

	// ==================================================
	// mtime counter
	// ==================================================

	// clear beats counting, the counter wraps at 32 bits
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			mtime <= '0;
		end else if (i_cfg.clear) begin
			mtime <= '0;
		end else if (i_cfg.enable) begin
			mtime <= mtime + 32'd1;
		end
	end

	// unsigned compare, held as a level while the match lasts
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_timer_irq <= 1'b0;
		end else begin
			o_timer_irq <= i_cfg.enable && (mtime >= i_cfg.cmp);
		end
	end

endmodule

// ==== hw/timer_regs.sv ====
module timer_regs (
	input  logic                 i_clock,
	input  logic                 i_reset,

	input  trap_pkg::wb_req_t    i_wb,
	output trap_pkg::xlen_t      o_wb_dat,
	output logic                 o_wb_ack,

	input  trap_pkg::xlen_t      i_mtime,
	output trap_pkg::timer_cfg_t o_cfg
);

	import trap_pkg::*;

	logic  ctrl_enable;
	logic  clear_pulse;
	xlen_t cmp;
	logic  access;

	// a new transfer starts while the previous ack is not showing
	assign access = i_wb.cyc && i_wb.stb && !o_wb_ack;

	assign o_cfg.enable = ctrl_enable;
	assign o_cfg.clear  = clear_pulse;
	assign o_cfg.cmp    = cmp;

	// ==================================================
	// register writes and ack
	// ==================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_wb_ack    <= 1'b0;
			ctrl_enable <= 1'b0;
			clear_pulse <= 1'b0;
			cmp         <= '0;
		end else begin
			o_wb_ack    <= access;
			clear_pulse <= 1'b0;
			if (access && i_wb.we) begin
				case (i_wb.adr[3:2])
					TMR_CTRL[3:2]: begin
						ctrl_enable <= i_wb.dat[0];
						clear_pulse <= i_wb.dat[1];
					end
					TMR_CMP[3:2]: cmp <= i_wb.dat;
					default: ;
				endcase
			end
		end
	end

	// read data is registered on the same edge as the ack
	always_ff @(posedge i_clock) begin
		if (access && !i_wb.we) begin
			case (i_wb.adr[3:2])
				TMR_CTRL[3:2]: o_wb_dat <= {31'b0, ctrl_enable};
				TMR_CMP[3:2]:  o_wb_dat <= cmp;
				TMR_TIME[3:2]: o_wb_dat <= i_mtime;
				default:       o_wb_dat <= '0;
			endcase
		end
	end

	a_ack_in_cycle: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_wb_ack |-> (i_wb.cyc && i_wb.stb)
	);

endmodule

// ==== hw/trap_pkg.sv ====
package trap_pkg;

	typedef logic [31:0] xlen_t;
	typedef logic [11:0] csr_addr_t;
	typedef logic [3:0]  wb_addr_t;

	// ==================================================
	// machine CSR indices
	// ==================================================
	localparam csr_addr_t CSR_MIE       = 12'h304;
	localparam csr_addr_t CSR_MTVEC     = 12'h305;
	localparam csr_addr_t CSR_MEPC      = 12'h341;
	localparam csr_addr_t CSR_MCAUSE    = 12'h342;
	localparam csr_addr_t CSR_MIP       = 12'h344;
	localparam csr_addr_t CSR_MVENDORID = 12'hF11;
	localparam csr_addr_t CSR_MARCHID   = 12'hF12;
	localparam csr_addr_t CSR_MIMPID    = 12'hF13;
	localparam csr_addr_t CSR_MHARTID   = 12'hF14;

	// read-only identification values
	localparam xlen_t MVENDORID = 32'h0000_0a5c;
	localparam xlen_t MARCHID   = 32'h0000_0017;
	localparam xlen_t MIMPID    = 32'h0001_0200;
	localparam xlen_t MHARTID   = 32'h0000_0000;

	// ==================================================
	// trap causes and interrupt bits
	// ==================================================
	localparam xlen_t CAUSE_M_TIMER    = 32'h8000_0007;
	localparam xlen_t CAUSE_M_EXTERNAL = 32'h8000_000B;
	localparam xlen_t CAUSE_ECALL_M    = 32'h0000_000B;

	// mie uses the same positions as mip, bit 3 is only stored
	localparam int MIP_MSIP_BIT = 3;
	localparam int MIP_MTIP_BIT = 7;
	localparam int MIP_MEIP_BIT = 11;

	// timer register byte offsets
	localparam wb_addr_t TMR_CTRL = 4'h0;
	localparam wb_addr_t TMR_CMP  = 4'h4;
	localparam wb_addr_t TMR_TIME = 4'h8;

	typedef struct packed {
		csr_addr_t index;
		logic      write;
		xlen_t     wdata;
	} csr_req_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		wb_addr_t adr;
		xlen_t    dat;
	} wb_req_t;

	typedef struct packed {
		logic  enable;
		logic  clear;
		xlen_t cmp;
	} timer_cfg_t;

endpackage

// ==== hw/trap_unit_top.sv ====
module trap_unit_top (
	input  logic               i_clock,
	input  logic               i_reset,

	input  trap_pkg::csr_req_t i_csr_req,
	output trap_pkg::xlen_t    o_csr_rdata,

	input  logic               i_external_interrupt,
	input  logic               i_ecall,

	output logic               o_irq_pending,
	output trap_pkg::xlen_t    o_irq_pc,
	input  logic               i_irq_dispatched,
	input  trap_pkg::xlen_t    i_irq_epc,
	output trap_pkg::xlen_t    o_epc,

	input  trap_pkg::wb_req_t  i_wb,
	output trap_pkg::xlen_t    o_wb_dat,
	output logic               o_wb_ack
);

	import trap_pkg::*;

	timer_cfg_t timer_cfg;
	xlen_t      mtime;
	logic       timer_irq;

	machine_csr u_csr (
		.i_clock              (i_clock),
		.i_reset              (i_reset),
		.i_csr_req            (i_csr_req),
		.o_csr_rdata          (o_csr_rdata),
		.i_timer_irq          (timer_irq),
		.i_external_interrupt (i_external_interrupt),
		.i_ecall              (i_ecall),
		.o_irq_pending        (o_irq_pending),
		.o_irq_pc             (o_irq_pc),
		.i_irq_dispatched     (i_irq_dispatched),
		.i_irq_epc            (i_irq_epc),
		.o_epc                (o_epc)
	);

	// timer setup arrives over Wishbone, mtime is read back the same way
	timer_regs u_timer_regs (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_wb     (i_wb),
		.o_wb_dat (o_wb_dat),
		.o_wb_ack (o_wb_ack),
		.i_mtime  (mtime),
		.o_cfg    (timer_cfg)
	);

	machine_timer u_timer (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_cfg       (timer_cfg),
		.o_mtime     (mtime),
		.o_timer_irq (timer_irq)
	);

endmodule
